/* Makefile */
# Verilator build and run for the slave link controller testbench

TOP = link_ctrl_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f link_ctrl.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee /dev/stderr | grep -x "Testbench passed" > /dev/null

clean:
	rm -rf obj_dir

/* bench/link_ctrl_tb.sv */
//////////////////////////////
// directed tests for the slave link controller
// ticks come from the bench
// one slot is 3750 clocks
// the DUT is reset before every test
//////////////////////////////
module link_ctrl_tb;

  localparam int TX_CREDITS  = 2;
  localparam int BACKOFF_W   = 10;
  localparam int CLKS_PER_US = 6;
  localparam int US_PER_SLOT = 625;
  localparam int SLOT_CLKS   = CLKS_PER_US * US_PER_SLOT;
  localparam int THRESH      = 58;
  localparam logic [63:0] DAC_WORD  = 64'h4E7A_19C3_B25D_F086;
  localparam logic [63:0] GIAC_WORD = 64'h9E8B_33A5_6C1D_24F7;

  // wait selectors
  localparam int SEL_PS        = 0;
  localparam int SEL_IS        = 1;
  localparam int SEL_SPR       = 2;
  localparam int SEL_IR        = 3;
  localparam int SEL_NEW_SLAVE = 4;
  localparam int SEL_TX_START  = 5;
  localparam int SEL_OVERRUN   = 6;

  logic clk_6M = 1'b0;
  logic rstz = 1'b0;
  logic p_1us = 1'b0;
  logic s_tslot_p = 1'b0;
  logic ps_enable_p, ps_cancel_p, is_enable_p, is_cancel_p;
  logic [15:0] ps_interval_slots, ps_window_slots, is_interval_slots, is_window_slots;
  logic [63:0] dac_sync, giac_sync, sync_in;
  logic [6:0] corr_threshold;
  logic [BACKOFF_W-1:0] max_backoff;
  logic rx_poll, lt_addressed, tx_credit;
  logic tx_start, tx_overrun, ps, is, spr, ir, conns, new_slave;
  logic page_scan_window, inq_scan_window;
  logic [4:0] fhs_count;
  lc_proto_pkg::tx_kind_e tx_kind;

  logic auto_credit = 1'b1;    // bench acts as the encoder
  logic echo_credit = 1'b0;
  logic manual_credit = 1'b0;
  int div_cnt = 0;
  int us_cnt = 0;
  logic [31:0] rng = 32'd61;
  int test_num = 0;
  int test_errors = 0;
  int total_errors = 0;
  int tests_failed = 0;

  assign tx_credit = auto_credit ? echo_credit : manual_credit;

  link_ctrl #(
    .TX_CREDITS (TX_CREDITS),
    .BACKOFF_W  (BACKOFF_W)
  ) dut_i (
    .clk_6M (clk_6M), .rstz (rstz), .p_1us (p_1us), .s_tslot_p (s_tslot_p),
    .ps_enable_p (ps_enable_p), .ps_cancel_p (ps_cancel_p),
    .is_enable_p (is_enable_p), .is_cancel_p (is_cancel_p),
    .ps_interval_slots (ps_interval_slots), .ps_window_slots (ps_window_slots),
    .is_interval_slots (is_interval_slots), .is_window_slots (is_window_slots),
    .dac_sync (dac_sync), .giac_sync (giac_sync), .corr_threshold (corr_threshold),
    .max_backoff (max_backoff), .sync_in (sync_in), .rx_poll (rx_poll),
    .lt_addressed (lt_addressed), .tx_credit (tx_credit), .tx_start (tx_start),
    .tx_kind (tx_kind), .ps (ps), .is (is), .spr (spr), .ir (ir), .conns (conns),
    .new_slave (new_slave), .fhs_count (fhs_count), .tx_overrun (tx_overrun),
    .page_scan_window (page_scan_window), .inq_scan_window (inq_scan_window)
  );

  always #10 clk_6M = ~clk_6M;

  //////////////////////////////
  // 1 us and slot ticks
  //////////////////////////////
  always @(negedge clk_6M)
  begin
    div_cnt = (div_cnt == CLKS_PER_US - 1) ? 0 : div_cnt + 1;
    p_1us   = (div_cnt == CLKS_PER_US - 1);
    if (p_1us)
      us_cnt = (us_cnt == US_PER_SLOT - 1) ? 0 : us_cnt + 1;
    s_tslot_p   = p_1us && (us_cnt == US_PER_SLOT - 1);
    echo_credit = tx_start;  // credit back one cycle after each start
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic bit sig_val(input int sel);
    case (sel)
      SEL_PS:        return ps;
      SEL_IS:        return is;
      SEL_SPR:       return spr;
      SEL_IR:        return ir;
      SEL_NEW_SLAVE: return new_slave;
      SEL_TX_START:  return tx_start;
      SEL_OVERRUN:   return tx_overrun;
      default:       return 1'b0;
    endcase
  endfunction

  task automatic check_val(input string name, input int got, input int exp);
    assert (got == exp)
    else
    begin
      $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic expect_ok(input bit ok, input string what);
    assert (ok)
    else
    begin
      $display("at %0t: %s", $time, what);
      test_errors++;
    end
  endtask

  // waits for a level and counts tx_start pulses meanwhile
  task automatic wait_level(input int sel, input bit val, input int max_cycles,
                            output bit ok, output int starts);
    int n;
    ok     = 1'b0;
    starts = 0;
    n      = 0;
    while (!ok && n < max_cycles)
    begin
      @(negedge clk_6M);
      n++;
      starts += int'(tx_start);
      ok = (sig_val(sel) == val);
    end
  endtask

  task automatic reset_dut();
    rstz              = 1'b0;
    ps_enable_p       = 1'b0;
    ps_cancel_p       = 1'b0;
    is_enable_p       = 1'b0;
    is_cancel_p       = 1'b0;
    ps_interval_slots = 16'd8;
    ps_window_slots   = 16'd8;  // window as long as the interval
    is_interval_slots = 16'd8;
    is_window_slots   = 16'd8;
    dac_sync          = DAC_WORD;
    giac_sync         = GIAC_WORD;
    corr_threshold    = 7'(THRESH);
    max_backoff       = BACKOFF_W'(20);
    sync_in           = '0;
    rx_poll           = 1'b0;
    lt_addressed      = 1'b0;
    auto_credit       = 1'b1;
    manual_credit     = 1'b0;
    repeat (5) @(negedge clk_6M);
    rstz = 1'b1;
    @(negedge clk_6M);
  endtask

  // one-cycle enable or cancel of a scan
  task automatic pulse_scan(input bit inquiry, input bit cancel);
    if (inquiry)
      {is_cancel_p, is_enable_p} = {cancel, !cancel};
    else
      {ps_cancel_p, ps_enable_p} = {cancel, !cancel};
    @(negedge clk_6M);
    {is_cancel_p, is_enable_p, ps_cancel_p, ps_enable_p} = 4'b0000;
  endtask

  task automatic make_flip_mask(input int n, output logic [63:0] mask);
    int draws;
    mask  = '0;
    draws = 0;
    while ($countones(mask) < n && draws < 1000)
    begin
      rng = xorshift32(rng);
      mask[rng[5:0]] = 1'b1;
      draws++;
    end
    check_val("flipped bits", $countones(mask), n);
  endtask

  task automatic finish_test(input string name);
    test_num++;
    total_errors += test_errors;
    if (test_errors != 0)
      tests_failed++;
    $display("test %0d %s: %s, %0d errors", test_num, name,
             (test_errors == 0) ? "ok" : "FAILED", test_errors);
    test_errors = 0;
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic idle_after_reset();
    int busy;
    reset_dut();
    busy = 0;
    check_val("status flags", int'({ps, is, spr, ir, conns, new_slave}), 0);
    check_val("tx_start", int'(tx_start), 0);
    check_val("tx_overrun", int'(tx_overrun), 0);
    check_val("fhs_count", int'(fhs_count), 0);
    for (int i = 0; i < 3 * SLOT_CLKS; i++)
    begin
      @(negedge clk_6M);
      if ({ps, is, spr, ir, conns, new_slave, tx_start, tx_overrun,
           page_scan_window, inq_scan_window} != '0 || fhs_count != '0)
        busy++;
    end
    check_val("cycles with activity", busy, 0);
    finish_test("idle after reset");
  endtask

  task automatic inquiry_response();
    bit ok;
    int starts;
    int fhs_before;
    reset_dut();
    is_window_slots = 16'd6;
    sync_in         = GIAC_WORD;
    pulse_scan(1'b1, 1'b0);
    wait_level(SEL_IS, 1'b1, 2 * SLOT_CLKS, ok, starts);
    expect_ok(ok, "is did not rise after the inquiry scan was enabled");
    check_val("inq_scan_window", int'(inq_scan_window), 1);
    fhs_before = int'(fhs_count);
    wait_level(SEL_TX_START, 1'b1, 3 * SLOT_CLKS, ok, starts);
    expect_ok(ok, "no tx_start for the inquiry response");
    check_val("tx_kind", int'(tx_kind), int'(lc_proto_pkg::FHS));
    check_val("ir", int'(ir), 1);
    wait_level(SEL_IR, 1'b0, 2 * SLOT_CLKS, ok, starts);
    expect_ok(ok, "ir stayed high past the FHS slot");
    check_val("fhs_count", int'(fhs_count), fhs_before + 1);
    wait_level(SEL_IS, 1'b1, SLOT_CLKS, ok, starts);  // backoff is 21 us
    expect_ok(ok, "is did not return after the backoff");
    check_val("inq_scan_window", int'(inq_scan_window), 1);
    pulse_scan(1'b1, 1'b1);
    finish_test("inquiry scan");
  endtask

  task automatic page_to_connection();
    bit ok;
    int starts;
    reset_dut();
    sync_in = DAC_WORD;
    pulse_scan(1'b0, 1'b0);
    wait_level(SEL_TX_START, 1'b1, 3 * SLOT_CLKS, ok, starts);
    expect_ok(ok, "no tx_start for the page response");
    check_val("tx_kind", int'(tx_kind), int'(lc_proto_pkg::ID));
    wait_level(SEL_SPR, 1'b1, 2, ok, starts);
    expect_ok(ok, "spr did not follow the ID");
    // word held so the FHS hits too
    wait_level(SEL_TX_START, 1'b1, 3 * SLOT_CLKS, ok, starts);
    expect_ok(ok, "no tx_start for the FHS acknowledge");
    check_val("tx_kind", int'(tx_kind), int'(lc_proto_pkg::ACK_ID));
    wait_level(SEL_NEW_SLAVE, 1'b1, 2 * SLOT_CLKS, ok, starts);
    expect_ok(ok, "new_slave did not rise");
    pulse_scan(1'b0, 1'b1);
    rx_poll      = 1'b1;
    lt_addressed = 1'b1;
    wait_level(SEL_TX_START, 1'b1, 2 * SLOT_CLKS, ok, starts);
    expect_ok(ok, "no tx_start for the poll acknowledge");
    check_val("tx_kind", int'(tx_kind), int'(lc_proto_pkg::NULL));
    wait_level(SEL_NEW_SLAVE, 1'b0, 2 * SLOT_CLKS, ok, starts);
    expect_ok(ok, "new_slave stayed high after the poll");
    check_val("conns", int'(conns), 1);
    rx_poll      = 1'b0;
    lt_addressed = 1'b0;
    finish_test("page scan to connection");
  endtask

  task automatic page_response_timeout();
    bit ok;
    int starts;
    reset_dut();
    sync_in = DAC_WORD;
    pulse_scan(1'b0, 1'b0);
    wait_level(SEL_TX_START, 1'b1, 3 * SLOT_CLKS, ok, starts);
    expect_ok(ok, "no tx_start for the page response");
    check_val("tx_kind", int'(tx_kind), int'(lc_proto_pkg::ID));
    sync_in = ~DAC_WORD;  // no bit matches
    wait_level(SEL_SPR, 1'b0, (lc_timing_pkg::RESP_TO_SLOTS + 2) * SLOT_CLKS, ok, starts);
    expect_ok(ok, "spr did not fall after the response timeout");
    check_val("tx_start pulses after the ID", starts, 0);
    check_val("ps", int'(ps), 1);
    finish_test("page response timeout");
  endtask

  task automatic correlation_threshold();
    bit ok;
    int starts;
    logic [63:0] mask;
    reset_dut();
    make_flip_mask(64 - THRESH + 1, mask);
    sync_in = DAC_WORD ^ mask;  // one match short of the threshold
    pulse_scan(1'b0, 1'b0);
    wait_level(SEL_PS, 1'b1, 2 * SLOT_CLKS, ok, starts);
    expect_ok(ok, "ps did not rise after the page scan was enabled");
    check_val("page_scan_window", int'(page_scan_window), 1);
    wait_level(SEL_TX_START, 1'b1, 2 * SLOT_CLKS, ok, starts);
    check_val("tx_start below threshold", int'(ok), 0);
    // exactly at the threshold
    make_flip_mask(64 - THRESH, mask);
    sync_in = DAC_WORD ^ mask;
    wait_level(SEL_TX_START, 1'b1, 2 * SLOT_CLKS, ok, starts);
    check_val("tx_start at threshold", int'(ok), 1);
    check_val("tx_kind", int'(tx_kind), int'(lc_proto_pkg::ID));
    finish_test("correlation threshold");
  endtask

  task automatic credit_flow_control();
    bit ok;
    int starts;
    int held;
    reset_dut();
    auto_credit = 1'b0;
    sync_in     = GIAC_WORD;
    pulse_scan(1'b1, 1'b0);
    for (int k = 0; k < TX_CREDITS; k++)
    begin
      wait_level(SEL_TX_START, 1'b1, 4 * SLOT_CLKS, ok, starts);
      expect_ok(ok, "inquiry response did not start while credits remained");
      check_val("tx_kind", int'(tx_kind), int'(lc_proto_pkg::FHS));
    end
    // next FHS request meets zero credits
    wait_level(SEL_IR, 1'b0, 2 * SLOT_CLKS, ok, starts);
    held = starts;
    wait_level(SEL_IR, 1'b1, 4 * SLOT_CLKS, ok, starts);
    expect_ok(ok, "no further FHS request came");
    wait_level(SEL_TX_START, 1'b1, 20, ok, starts);
    check_val("tx_start without credit", held + starts, 0);
    manual_credit = 1'b1;
    @(negedge clk_6M);
    manual_credit = 1'b0;
    check_val("tx_start after credit", int'(tx_start), 1);
    check_val("tx_kind", int'(tx_kind), int'(lc_proto_pkg::FHS));
    // one request held and one more on top
    for (int k = 0; k < 2; k++)
    begin
      wait_level(SEL_IR, 1'b0, 2 * SLOT_CLKS, ok, starts);
      held = starts;
      wait_level(SEL_IR, 1'b1, 4 * SLOT_CLKS, ok, starts);
      expect_ok(ok, "no further FHS request came");
      check_val("tx_start without credit", held + starts, 0);
      check_val("tx_overrun", int'(tx_overrun), k);
    end
    wait_level(SEL_OVERRUN, 1'b0, SLOT_CLKS, ok, starts);
    check_val("tx_overrun cleared", int'(ok), 0);
    finish_test("credit flow control");
  endtask

  initial
  begin
    idle_after_reset();
    inquiry_response();
    page_to_connection();
    page_response_timeout();
    correlation_threshold();
    credit_flow_control();
    $display("tests run %0d, failed %0d, errors %0d", test_num, tests_failed, total_errors);
    if (total_errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

/* link_ctrl.f */
src/lc_timing_pkg.sv
src/lc_proto_pkg.sv
src/corr_if.sv
src/scan_window_timer.sv
src/sync_correlator.sv
src/slave_link_fsm.sv
src/tx_credit_issuer.sv
src/link_ctrl.sv
bench/link_ctrl_tb.sv

/* src/corr_if.sv */
//////////////////////////////
// FSM to correlator link
// markers are single cycle pulses
//////////////////////////////
interface corr_if;

  logic corr_window;    // correlation allowed
  logic use_giac;       // reference select, else DAC
  logic hit_p;          // threshold reached
  logic slot_dly_endp;  // one slot after the hit
  logic half_dly_endp;  // half slot after the hit

  modport fsm_mp (
    output corr_window, use_giac,
    input  hit_p, slot_dly_endp, half_dly_endp
  );

  modport corr_mp (
    input  corr_window, use_giac,
    output hit_p, slot_dly_endp, half_dly_endp
  );

endinterface

/* src/lc_proto_pkg.sv */
//////////////////////////////
// link states and packet kinds of the slave side only
// master, hold, sniff and park states are not encoded
//////////////////////////////
package lc_proto_pkg;

  // access code width
  localparam int unsigned SYNC_W = 64;

  // match count, holds 0..SYNC_W
  localparam int unsigned CORR_CNT_W = 7;

  //////////////////////////////
  // slave link states
  //////////////////////////////
  typedef enum logic [4:0] {
    STANDBY,
    INQ_SCAN,
    INQ_TX_FHS,
    INQ_BACKOFF,
    PAGE_SCAN,
    SPR_TX_ID,
    SPR_RX_FHS,
    SPR_RX_FHS_DONE,
    SPR_ACK_FHS,
    NEW_SLAVE,
    NEW_SLAVE_ACK_POLL,
    ACTIVE
  } link_state_e;

  // packets handed to the encoder
  typedef enum logic [1:0] {
    ID,      // page response
    ACK_ID,  // acknowledges the FHS
    FHS,     // inquiry response
    NULL     // acknowledges a poll
  } tx_kind_e;

endpackage

/* src/lc_timing_pkg.sv */
//////////////////////////////
// slot and microsecond timing for the slave link controller
// counts assume a 1 us tick and 625 us slots
//////////////////////////////
package lc_timing_pkg;

  // microsecond counters
  localparam int unsigned US_CNT_W = 11;

  // slot end, counted from the start event
  localparam int unsigned SLOT_END_US = 624;

  // half slot minus the rx/tx turnaround
  localparam int unsigned HALF_SLOT_END_US = 302;

  // two slots, the ack-FHS window
  localparam int unsigned TWO_SLOT_END_US = 1249;

  //////////////////////////////
  // scan and timeout slot counts
  //////////////////////////////
  localparam int unsigned SCAN_CNT_W = 16;

  localparam int unsigned RESP_TO_SLOTS    = 8;   // page response, no FHS
  localparam int unsigned NEWCONN_TO_SLOTS = 16;  // slot pairs, no poll

endpackage

/* src/link_ctrl.sv */
//////////////////////////////
// slave link controller top, plain ports
// p_1us and s_tslot_p come from outside, s_tslot_p on a p_1us cycle
//////////////////////////////
module link_ctrl #(
  parameter int TX_CREDITS = 2,
  parameter int BACKOFF_W  = 10
) (
  input  logic                                  clk_6M,
  input  logic                                  rstz,
  input  logic                                  p_1us,
  input  logic                                  s_tslot_p,
  input  logic                                  ps_enable_p,
  input  logic                                  ps_cancel_p,
  input  logic                                  is_enable_p,
  input  logic                                  is_cancel_p,
  input  logic [lc_timing_pkg::SCAN_CNT_W-1:0]  ps_interval_slots,
  input  logic [lc_timing_pkg::SCAN_CNT_W-1:0]  ps_window_slots,
  input  logic [lc_timing_pkg::SCAN_CNT_W-1:0]  is_interval_slots,
  input  logic [lc_timing_pkg::SCAN_CNT_W-1:0]  is_window_slots,
  input  logic [lc_proto_pkg::SYNC_W-1:0]       dac_sync,
  input  logic [lc_proto_pkg::SYNC_W-1:0]       giac_sync,
  input  logic [lc_proto_pkg::CORR_CNT_W-1:0]   corr_threshold,
  input  logic [BACKOFF_W-1:0]                  max_backoff,
  input  logic [lc_proto_pkg::SYNC_W-1:0]       sync_in,
  input  logic                                  rx_poll,
  input  logic                                  lt_addressed,
  input  logic                                  tx_credit,
  output logic                                  tx_start,
  output lc_proto_pkg::tx_kind_e                tx_kind,
  output logic                                  ps,
  output logic                                  is,
  output logic                                  spr,
  output logic                                  ir,
  output logic                                  conns,
  output logic                                  new_slave,
  output logic [4:0]                            fhs_count,
  output logic                                  tx_overrun,
  output logic                                  page_scan_window,
  output logic                                  inq_scan_window
);

  logic                   tx_req;
  lc_proto_pkg::tx_kind_e req_kind;

  corr_if corr_i ();

  scan_window_timer ps_timer_i (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .s_tslot_p      (s_tslot_p),
    .enable_p       (ps_enable_p),
    .cancel_p       (ps_cancel_p),
    .interval_slots (ps_interval_slots),
    .window_slots   (ps_window_slots),
    .scan_window    (page_scan_window)
  );

  scan_window_timer is_timer_i (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .s_tslot_p      (s_tslot_p),
    .enable_p       (is_enable_p),
    .cancel_p       (is_cancel_p),
    .interval_slots (is_interval_slots),
    .window_slots   (is_window_slots),
    .scan_window    (inq_scan_window)
  );

  sync_correlator sync_correlator_i (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .p_1us          (p_1us),
    .sync_in        (sync_in),
    .dac_sync       (dac_sync),
    .giac_sync      (giac_sync),
    .corr_threshold (corr_threshold),
    .corr           (corr_i)
  );

  slave_link_fsm #(
    .BACKOFF_W (BACKOFF_W)
  ) slave_link_fsm_i (
    .clk_6M           (clk_6M),
    .rstz             (rstz),
    .p_1us            (p_1us),
    .s_tslot_p        (s_tslot_p),
    .page_scan_window (page_scan_window),
    .inq_scan_window  (inq_scan_window),
    .rx_poll          (rx_poll),
    .lt_addressed     (lt_addressed),
    .max_backoff      (max_backoff),
    .corr             (corr_i),
    .tx_req           (tx_req),
    .req_kind         (req_kind),
    .ps               (ps),
    .is               (is),
    .spr              (spr),
    .ir               (ir),
    .conns            (conns),
    .new_slave        (new_slave),
    .fhs_count        (fhs_count)
  );

  tx_credit_issuer #(
    .TX_CREDITS (TX_CREDITS)
  ) tx_credit_issuer_i (
    .clk_6M     (clk_6M),
    .rstz       (rstz),
    .tx_req     (tx_req),
    .req_kind   (req_kind),
    .tx_credit  (tx_credit),
    .tx_start   (tx_start),
    .tx_kind    (tx_kind),
    .tx_overrun (tx_overrun)
  );

endmodule

/* src/scan_window_timer.sv */
//////////////////////////////
// scan window timer, one per scan type
// window longer than interval keeps it open, zero interval acts as one
//////////////////////////////
module scan_window_timer (
  input  logic                                 clk_6M,
  input  logic                                 rstz,
  input  logic                                 s_tslot_p,
  input  logic                                 enable_p,
  input  logic                                 cancel_p,
  input  logic [lc_timing_pkg::SCAN_CNT_W-1:0] interval_slots,
  input  logic [lc_timing_pkg::SCAN_CNT_W-1:0] window_slots,
  output logic                                 scan_window
);

  logic                                 enabled;
  logic [lc_timing_pkg::SCAN_CNT_W-1:0] slot_cnt;
  logic                                 last_slot;

  assign last_slot = (slot_cnt + 1'b1) >= interval_slots;

  // enable latch, cancel wins
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      enabled <= 1'b0;
    else if (cancel_p)
      enabled <= 1'b0;
    else if (enable_p)
      enabled <= 1'b1;
  end

  //////////////////////////////
  // slot count modulo interval
  //////////////////////////////
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      slot_cnt    <= '0;
      scan_window <= 1'b0;
    end
    else if (s_tslot_p)
    begin
      if (!enabled)
      begin
        slot_cnt    <= '0;
        scan_window <= 1'b0;
      end
      else
      begin
        scan_window <= slot_cnt < window_slots;  // first slots of each interval
        slot_cnt    <= last_slot ? '0 : slot_cnt + 1'b1;
      end
    end
  end

endmodule

/* src/slave_link_fsm.sv */
//////////////////////////////
// slave link FSM, scan to response to connection
// scans return to standby or active, whichever they left
// a hit is only acted on inside the state that saw it
//////////////////////////////
module slave_link_fsm #(
  parameter int BACKOFF_W = 10
) (
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic                  p_1us,
  input  logic                  s_tslot_p,
  input  logic                  page_scan_window,
  input  logic                  inq_scan_window,
  input  logic                  rx_poll,
  input  logic                  lt_addressed,
  input  logic [BACKOFF_W-1:0]  max_backoff,
  corr_if.fsm_mp                corr,
  output logic                  tx_req,
  output lc_proto_pkg::tx_kind_e req_kind,
  output logic                  ps,
  output logic                  is,
  output logic                  spr,
  output logic                  ir,
  output logic                  conns,
  output logic                  new_slave,
  output logic [4:0]            fhs_count
);

  localparam int TO_W = $clog2(2 * lc_timing_pkg::NEWCONN_TO_SLOTS + 1);

  lc_proto_pkg::link_state_e          cs, ns, ret_state;
  logic                               ret_active;  // scan entered from active
  logic                               hit_seen;
  logic [lc_timing_pkg::US_CNT_W-1:0] us_cnt;
  logic [BACKOFF_W-1:0]               bo_cnt;
  logic [TO_W-1:0]                    to_cnt;
  logic                               slot_us_end, bo_end, resp_to, newconn_to;

  assign ret_state   = ret_active ? lc_proto_pkg::ACTIVE : lc_proto_pkg::STANDBY;
  assign slot_us_end = p_1us && (us_cnt == lc_timing_pkg::SLOT_END_US);
  assign bo_end      = p_1us && (bo_cnt == max_backoff);
  assign resp_to     = s_tslot_p && (to_cnt == TO_W'(lc_timing_pkg::RESP_TO_SLOTS - 1));
  assign newconn_to  = s_tslot_p && (to_cnt == TO_W'(2 * lc_timing_pkg::NEWCONN_TO_SLOTS - 1));

  //////////////////////////////
  // state register
  //////////////////////////////
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      cs         <= lc_proto_pkg::STANDBY;
      ret_active <= 1'b0;
    end
    else
    begin
      cs <= ns;
      if (cs == lc_proto_pkg::STANDBY || cs == lc_proto_pkg::ACTIVE)
        ret_active <= (cs == lc_proto_pkg::ACTIVE);
    end
  end

  always_comb
  begin
    ns       = cs;
    tx_req   = 1'b0;
    req_kind = lc_proto_pkg::ID;
    case (cs)
      lc_proto_pkg::STANDBY, lc_proto_pkg::ACTIVE:
      begin
        if (inq_scan_window)
          ns = lc_proto_pkg::INQ_SCAN;
        else if (page_scan_window)
          ns = lc_proto_pkg::PAGE_SCAN;
      end
      lc_proto_pkg::INQ_SCAN:
      begin
        if (!inq_scan_window)
          ns = ret_state;
        else if (hit_seen && corr.slot_dly_endp)
        begin
          ns       = lc_proto_pkg::INQ_TX_FHS;
          tx_req   = 1'b1;
          req_kind = lc_proto_pkg::FHS;
        end
      end
      lc_proto_pkg::INQ_TX_FHS:
        if (slot_us_end)
          ns = lc_proto_pkg::INQ_BACKOFF;
      lc_proto_pkg::INQ_BACKOFF:
        if (bo_end)
          ns = lc_proto_pkg::INQ_SCAN;  // random wait against collisions
      lc_proto_pkg::PAGE_SCAN:
      begin
        if (!page_scan_window)
          ns = ret_state;
        else if (hit_seen && corr.slot_dly_endp)
        begin
          ns     = lc_proto_pkg::SPR_TX_ID;
          tx_req = 1'b1;
        end
      end
      lc_proto_pkg::SPR_TX_ID:
        if (corr.half_dly_endp)
          ns = lc_proto_pkg::SPR_RX_FHS;
      lc_proto_pkg::SPR_RX_FHS:
      begin
        if (corr.hit_p)
          ns = lc_proto_pkg::SPR_RX_FHS_DONE;
        else if (resp_to)
          ns = lc_proto_pkg::PAGE_SCAN;
      end
      lc_proto_pkg::SPR_RX_FHS_DONE:
        if (s_tslot_p)
        begin
          ns       = lc_proto_pkg::SPR_ACK_FHS;
          tx_req   = 1'b1;
          req_kind = lc_proto_pkg::ACK_ID;
        end
      lc_proto_pkg::SPR_ACK_FHS:
        if (s_tslot_p)
          ns = lc_proto_pkg::NEW_SLAVE;
      lc_proto_pkg::NEW_SLAVE:
      begin
        if (s_tslot_p && rx_poll && lt_addressed)
        begin
          ns       = lc_proto_pkg::NEW_SLAVE_ACK_POLL;
          tx_req   = 1'b1;
          req_kind = lc_proto_pkg::NULL;
        end
        else if (newconn_to)
          ns = lc_proto_pkg::PAGE_SCAN;
      end
      lc_proto_pkg::NEW_SLAVE_ACK_POLL:
        if (s_tslot_p)
          ns = lc_proto_pkg::ACTIVE;
      default:
        ns = lc_proto_pkg::STANDBY;
    endcase
  end

  //////////////////////////////
  // counters, cleared on any state change
  //////////////////////////////
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      hit_seen <= 1'b0;
      us_cnt   <= '0;
      bo_cnt   <= '0;
      to_cnt   <= '0;
    end
    else if (ns != cs)
    begin
      hit_seen <= 1'b0;
      us_cnt   <= '0;
      bo_cnt   <= '0;
      to_cnt   <= '0;
    end
    else
    begin
      hit_seen <= hit_seen || corr.hit_p;
      if (p_1us && us_cnt != lc_timing_pkg::TWO_SLOT_END_US)
        us_cnt <= us_cnt + 1'b1;  // saturates at the ack-FHS window
      if (p_1us && cs == lc_proto_pkg::INQ_BACKOFF)
        bo_cnt <= bo_cnt + 1'b1;
      if (s_tslot_p && (cs == lc_proto_pkg::SPR_RX_FHS || cs == lc_proto_pkg::NEW_SLAVE))
        to_cnt <= to_cnt + 1'b1;
    end
  end

  // FHS responses sent
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      fhs_count <= '0;
    else if (cs == lc_proto_pkg::INQ_TX_FHS && slot_us_end)
      fhs_count <= fhs_count + 1'b1;
  end

  assign corr.corr_window = (cs == lc_proto_pkg::INQ_SCAN) || (cs == lc_proto_pkg::PAGE_SCAN) ||
                            (cs == lc_proto_pkg::SPR_RX_FHS);
  assign corr.use_giac    = (cs == lc_proto_pkg::INQ_SCAN);

  assign ps        = (cs == lc_proto_pkg::PAGE_SCAN);
  assign is        = (cs == lc_proto_pkg::INQ_SCAN);
  assign ir        = (cs == lc_proto_pkg::INQ_TX_FHS);
  assign spr       = (cs == lc_proto_pkg::SPR_TX_ID) || (cs == lc_proto_pkg::SPR_RX_FHS) ||
                     (cs == lc_proto_pkg::SPR_RX_FHS_DONE) || (cs == lc_proto_pkg::SPR_ACK_FHS);
  assign new_slave = (cs == lc_proto_pkg::NEW_SLAVE) || (cs == lc_proto_pkg::NEW_SLAVE_ACK_POLL);
  assign conns     = new_slave || (cs == lc_proto_pkg::ACTIVE);

endmodule

/* src/sync_correlator.sv */
//////////////////////////////
// sync word correlator, bitwise match count against DAC or GIAC
// rearms once the window closes or the count drops below threshold
// delay markers repeat every slot after the latest hit
//////////////////////////////
module sync_correlator (
  input  logic                                  clk_6M,
  input  logic                                  rstz,
  input  logic                                  p_1us,
  input  logic [lc_proto_pkg::SYNC_W-1:0]       sync_in,
  input  logic [lc_proto_pkg::SYNC_W-1:0]       dac_sync,
  input  logic [lc_proto_pkg::SYNC_W-1:0]       giac_sync,
  input  logic [lc_proto_pkg::CORR_CNT_W-1:0]   corr_threshold,
  corr_if.corr_mp                               corr
);

  logic [lc_proto_pkg::SYNC_W-1:0]     ref_word;
  logic [lc_proto_pkg::CORR_CNT_W-1:0] match_cnt;
  logic                                above;
  logic                                fired;
  logic                                dly_run;
  logic [lc_timing_pkg::US_CNT_W-1:0]  dly_cnt;

  assign ref_word = corr.use_giac ? giac_sync : dac_sync;

  // count of equal bit positions
  always_comb
  begin
    match_cnt = '0;
    for (int i = 0; i < lc_proto_pkg::SYNC_W; i++)
      match_cnt = match_cnt + lc_proto_pkg::CORR_CNT_W'(sync_in[i] ~^ ref_word[i]);
  end

  assign above = corr.corr_window && (match_cnt >= corr_threshold);

  //////////////////////////////
  // hit pulse, one per crossing
  //////////////////////////////
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      fired      <= 1'b0;
      corr.hit_p <= 1'b0;
    end
    else
    begin
      fired      <= above;
      corr.hit_p <= above && !fired;
    end
  end

  // us count since the hit, wraps each slot
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      dly_run <= 1'b0;
      dly_cnt <= '0;
    end
    else if (corr.hit_p)
    begin
      dly_run <= 1'b1;  // restart on every hit
      dly_cnt <= '0;
    end
    else if (dly_run && p_1us)
      dly_cnt <= (dly_cnt == lc_timing_pkg::SLOT_END_US) ? '0 : dly_cnt + 1'b1;
  end

  assign corr.half_dly_endp = dly_run && p_1us && (dly_cnt == lc_timing_pkg::HALF_SLOT_END_US);
  assign corr.slot_dly_endp = dly_run && p_1us && (dly_cnt == lc_timing_pkg::SLOT_END_US);

endmodule

/* src/tx_credit_issuer.sv */
//////////////////////////////
// transmit request issuer with encoder credits
// one held request, a newer one overwrites it and flags overrun
//////////////////////////////
module tx_credit_issuer #(
  parameter int TX_CREDITS = 2
) (
  input  logic                   clk_6M,
  input  logic                   rstz,
  input  logic                   tx_req,
  input  lc_proto_pkg::tx_kind_e req_kind,
  input  logic                   tx_credit,
  output logic                   tx_start,
  output lc_proto_pkg::tx_kind_e tx_kind,
  output logic                   tx_overrun
);

  localparam int CRED_W = $clog2(TX_CREDITS + 1);

  logic [CRED_W-1:0]      credits;
  logic                   pending;
  lc_proto_pkg::tx_kind_e pend_kind;
  logic                   launch_pend, launch_req, hold_req;

  assign launch_pend = pending && (tx_credit || credits != '0);
  assign launch_req  = tx_req && !pending && (credits != '0);
  assign hold_req    = tx_req && !launch_req;

  //////////////////////////////
  // credits and hold register
  //////////////////////////////
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      credits    <= CRED_W'(TX_CREDITS);
      pending    <= 1'b0;
      tx_start   <= 1'b0;
      tx_kind    <= lc_proto_pkg::ID;
      tx_overrun <= 1'b0;
    end
    else
    begin
      credits  <= credits + CRED_W'(tx_credit) - CRED_W'(launch_pend || launch_req);
      tx_start <= launch_pend || launch_req;
      if (launch_pend)
        tx_kind <= pend_kind;  // older request goes first
      else if (launch_req)
        tx_kind <= req_kind;
      if (hold_req)
        pending <= 1'b1;
      else if (launch_pend)
        pending <= 1'b0;
      if (hold_req && pending && !launch_pend)
        tx_overrun <= 1'b1;  // sticky
    end
  end

  always_ff @(posedge clk_6M)
  begin
    if (hold_req)
      pend_kind <= req_kind;
  end

endmodule
